/* src.f */
dmi_pkg.sv
dmi_fifo.sv
dmi_source_mux.sv
debug_req_gate.sv
dm_regs.sv
dmi_harness.sv
tb_dmi_harness.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module tb_dmi_harness -o tb_dmi_harness
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_dmi_harness)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

/* tb_dmi_harness.sv */
`timescale 1ns/1ps

module tb_dmi_harness;
  import dmi_pkg::*;

  localparam logic                    SideJtag      = 1'b1;
  localparam logic                    SideDtm       = 1'b0;
  localparam logic [31:0]             JtagExit      = 32'h0000_0a11;
  localparam logic [31:0]             DtmExit       = 32'h0000_0d7e;
  localparam logic [31:0]             DmControlMask = 32'h8000_0003;
  localparam logic [DmiAddrWidth-1:0] UnmappedAddr  = 7'h7f;
  // Tests need a few hundred cycles, so this leaves a wide margin
  localparam int unsigned             TimeoutCycles = 2000;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    jtag_sel_i;
  logic                    jtag_req_valid_i;
  logic                    jtag_req_ready_o;
  logic [DmiAddrWidth-1:0] jtag_req_addr_i;
  dtm_op_e                 jtag_req_op_i;
  logic [DmiDataWidth-1:0] jtag_req_data_i;
  logic                    jtag_resp_valid_o;
  logic                    jtag_resp_ready_i;
  logic [DmiDataWidth-1:0] jtag_resp_data_o;
  dmi_resp_e               jtag_resp_code_o;
  logic                    dtm_req_valid_i;
  logic                    dtm_req_ready_o;
  logic [DmiAddrWidth-1:0] dtm_req_addr_i;
  dtm_op_e                 dtm_req_op_i;
  logic [DmiDataWidth-1:0] dtm_req_data_i;
  logic                    dtm_resp_valid_o;
  logic                    dtm_resp_ready_i;
  logic [DmiDataWidth-1:0] dtm_resp_data_o;
  dmi_resp_e               dtm_resp_code_o;
  logic [31:0]             jtag_exit_i;
  logic [31:0]             dtm_exit_i;
  logic [31:0]             exit_o;
  logic                    debug_req_o;
  logic                    ndmreset_o;

  integer                  seed;
  int unsigned             cycle_cnt = 0;
  logic [DmiDataWidth-1:0] exp_data [NrDataRegs];

  dmi_harness u_dut (.*);

  always #2 clk_i = ~clk_i;

  // ----------------------------------------
  // Failure handling and checks
  // ----------------------------------------
  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      cycle_cnt <= cycle_cnt + 1;
    end
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      end_in_failure();
    end
  end

  task automatic check_resp_data(input string what, input logic [DmiDataWidth-1:0] exp,
                                 input logic [DmiDataWidth-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, what, exp, act);
      end_in_failure();
    end
  endtask

  task automatic check_resp_code(input string what, input dmi_resp_e exp,
                                 input dmi_resp_e act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %s, got %s", $time, what, exp.name(),
               act.name());
      end_in_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, what, exp, act);
      end_in_failure();
    end
  endtask

  // ----------------------------------------
  // Requester drivers
  // ----------------------------------------
  task automatic set_req(input logic side, input logic valid, input dtm_op_e op,
                         input logic [DmiAddrWidth-1:0] addr,
                         input logic [DmiDataWidth-1:0] data);
    if (side) begin
      jtag_req_valid_i = valid;
      jtag_req_op_i    = op;
      jtag_req_addr_i  = addr;
      jtag_req_data_i  = data;
    end else begin
      dtm_req_valid_i = valid;
      dtm_req_op_i    = op;
      dtm_req_addr_i  = addr;
      dtm_req_data_i  = data;
    end
  endtask

  task automatic set_resp_ready(input logic ready);
    jtag_resp_ready_i = ready;
    dtm_resp_ready_i  = ready;
  endtask

  function automatic logic req_ready(input logic side);
    return side ? jtag_req_ready_o : dtm_req_ready_o;
  endfunction

  function automatic logic resp_valid(input logic side);
    return side ? jtag_resp_valid_o : dtm_resp_valid_o;
  endfunction

  // Unselected requester must stay fully gated
  task automatic check_unselected_idle(input logic side);
    check_bit("unselected req_ready", 1'b0, req_ready(side));
    check_bit("unselected resp_valid", 1'b0, resp_valid(side));
  endtask

  task automatic dmi_access(input logic side, input dtm_op_e op,
                            input logic [DmiAddrWidth-1:0] addr,
                            input logic [DmiDataWidth-1:0] wdata,
                            output logic [DmiDataWidth-1:0] rdata, output dmi_resp_e code);
    set_req(side, 1'b1, op, addr, wdata);
    while (!req_ready(side)) begin
      check_unselected_idle(!side);
      @(posedge clk_i);
      #1;
    end
    @(posedge clk_i);
    #1;
    set_req(side, 1'b0, DTM_NOP, '0, '0);
    while (!resp_valid(side)) begin
      check_unselected_idle(!side);
      @(posedge clk_i);
      #1;
    end
    rdata = side ? jtag_resp_data_o : dtm_resp_data_o;
    code  = side ? jtag_resp_code_o : dtm_resp_code_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic read_all_regs(input logic side);
    logic [DmiDataWidth-1:0] rdata;
    dmi_resp_e               code;
    for (int i = 0; i < NrDataRegs; i++) begin
      dmi_access(side, DTM_READ, DataRegBase + DmiAddrWidth'(i), '0, rdata, code);
      check_resp_data("data register read", exp_data[i], rdata);
      check_resp_code("data register read code", DMI_SUCCESS, code);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_after_reset();
    check_bit("debug_req_o after reset", 1'b0, debug_req_o);
    check_bit("ndmreset_o after reset", 1'b0, ndmreset_o);
    check_bit("jtag_resp_valid_o after reset", 1'b0, jtag_resp_valid_o);
    check_bit("dtm_resp_valid_o after reset", 1'b0, dtm_resp_valid_o);
    check_resp_data("exit_o with DTM selected", DtmExit, exit_o);
  endtask

  task automatic test_halt_gating();
    logic [DmiDataWidth-1:0] rdata;
    dmi_resp_e               code;
    logic [DmiDataWidth-1:0] wdata;
    wdata = 32'h8123_4567;
    dmi_access(SideDtm, DTM_WRITE, DmControlAddr, wdata, rdata, code);
    check_resp_code("dmcontrol write code", DMI_SUCCESS, code);
    check_bit("ndmreset_o after dmcontrol write", 1'b1, ndmreset_o);
    while (cycle_cnt < DmiDelCycles) begin
      check_bit("debug_req_o inside the post-reset window", 1'b0, debug_req_o);
      @(posedge clk_i);
      #1;
    end
    check_bit("debug_req_o after the post-reset window", 1'b1, debug_req_o);
    dmi_access(SideDtm, DTM_READ, DmControlAddr, '0, rdata, code);
    check_resp_data("dmcontrol read", wdata & DmControlMask, rdata);
    // Drop haltreq first, then ndmreset
    dmi_access(SideDtm, DTM_WRITE, DmControlAddr, 32'h0000_0003, rdata, code);
    check_bit("debug_req_o after haltreq cleared", 1'b0, debug_req_o);
    dmi_access(SideDtm, DTM_WRITE, DmControlAddr, '0, rdata, code);
    check_bit("ndmreset_o after clear", 1'b0, ndmreset_o);
  endtask

  task automatic test_data_regs();
    logic [DmiDataWidth-1:0] rdata;
    dmi_resp_e               code;
    for (int i = 0; i < NrDataRegs; i++) begin
      exp_data[i] = $random(seed);
      dmi_access(SideDtm, DTM_WRITE, DataRegBase + DmiAddrWidth'(i), exp_data[i], rdata, code);
      check_resp_data("data register write", '0, rdata);
      check_resp_code("data register write code", DMI_SUCCESS, code);
    end
    read_all_regs(SideDtm);
  endtask

  task automatic test_decode();
    logic [DmiDataWidth-1:0] rdata;
    dmi_resp_e               code;
    dmi_access(SideDtm, DTM_READ, UnmappedAddr, '0, rdata, code);
    check_resp_data("unmapped read", '0, rdata);
    check_resp_code("unmapped read code", DMI_FAILED, code);
    dmi_access(SideDtm, DTM_WRITE, DataRegLast + 7'h1, 32'hdead_beef, rdata, code);
    check_resp_code("unmapped write code", DMI_FAILED, code);
    dmi_access(SideDtm, DTM_NOP, DataRegBase, 32'h1234_5678, rdata, code);
    check_resp_data("nop", '0, rdata);
    check_resp_code("nop code", DMI_SUCCESS, code);
    read_all_regs(SideDtm);
  endtask

  task automatic test_source_select();
    jtag_sel_i = 1'b1;
    @(posedge clk_i);
    #1;
    check_resp_data("exit_o with JTAG selected", JtagExit, exit_o);
    read_all_regs(SideJtag);
  endtask

  task automatic test_back_pressure();
    int unsigned sent;
    int unsigned got;
    logic        req_fire;
    logic        resp_fire;
    set_resp_ready(1'b0);
    sent = 0;
    exp_data[0] = $random(seed);
    set_req(SideJtag, 1'b1, DTM_WRITE, DataRegBase, exp_data[0]);
    while (req_ready(SideJtag)) begin
      @(posedge clk_i);
      #1;
      sent++;
      if (sent == NrDataRegs) begin
        $display("Back-pressure test: req_ready never went low with resp_ready held low");
        end_in_failure();
      end
      exp_data[sent] = $random(seed);
      set_req(SideJtag, 1'b1, DTM_WRITE, DataRegBase + DmiAddrWidth'(sent), exp_data[sent]);
    end
    // Stalled write stays valid and completes after release
    set_resp_ready(1'b1);
    got = 0;
    while (got < sent + 1) begin
      req_fire  = jtag_req_valid_i & jtag_req_ready_o;
      resp_fire = jtag_resp_valid_o;
      if (resp_fire) begin
        check_resp_data("buffered write response", '0, jtag_resp_data_o);
        check_resp_code("buffered write code", DMI_SUCCESS, jtag_resp_code_o);
      end
      @(posedge clk_i);
      #1;
      if (req_fire) begin
        set_req(SideJtag, 1'b0, DTM_NOP, '0, '0);
      end
      if (resp_fire) begin
        got++;
      end
    end
    read_all_regs(SideJtag);
  endtask

  initial begin
    seed   = 32'h7f3d_ac4f;
    clk_i  = 1'b0;
    rst_ni = 1'b0;
    jtag_sel_i  = 1'b0;
    jtag_exit_i = JtagExit;
    dtm_exit_i  = DtmExit;
    set_req(SideJtag, 1'b0, DTM_NOP, '0, '0);
    set_req(SideDtm, 1'b0, DTM_NOP, '0, '0);
    set_resp_ready(1'b1);
    for (int i = 0; i < NrDataRegs; i++) begin
      exp_data[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_after_reset();
    test_halt_gating();
    test_data_regs();
    test_decode();
    test_source_select();
    test_back_pressure();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* dmi_harness.sv */
`timescale 1ns/1ps

module dmi_harness (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             jtag_sel_i,

  input  logic                             jtag_req_valid_i,
  output logic                             jtag_req_ready_o,
  input  logic [dmi_pkg::DmiAddrWidth-1:0] jtag_req_addr_i,
  input  dmi_pkg::dtm_op_e                 jtag_req_op_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0] jtag_req_data_i,
  output logic                             jtag_resp_valid_o,
  input  logic                             jtag_resp_ready_i,
  output logic [dmi_pkg::DmiDataWidth-1:0] jtag_resp_data_o,
  output dmi_pkg::dmi_resp_e               jtag_resp_code_o,

  input  logic                             dtm_req_valid_i,
  output logic                             dtm_req_ready_o,
  input  logic [dmi_pkg::DmiAddrWidth-1:0] dtm_req_addr_i,
  input  dmi_pkg::dtm_op_e                 dtm_req_op_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0] dtm_req_data_i,
  output logic                             dtm_resp_valid_o,
  input  logic                             dtm_resp_ready_i,
  output logic [dmi_pkg::DmiDataWidth-1:0] dtm_resp_data_o,
  output dmi_pkg::dmi_resp_e               dtm_resp_code_o,

  input  logic [31:0]                      jtag_exit_i,
  input  logic [31:0]                      dtm_exit_i,
  output logic [31:0]                      exit_o,

  output logic                             debug_req_o,
  output logic                             ndmreset_o
);
  import dmi_pkg::*;

  logic      mux_req_valid;
  logic      mux_req_ready;
  dmi_req_t  mux_req;
  logic      dm_req_valid;
  logic      dm_req_ready;
  dmi_req_t  dm_req;
  logic      dm_resp_valid;
  logic      dm_resp_ready;
  dmi_resp_t dm_resp;
  logic      mux_resp_valid;
  logic      mux_resp_ready;
  dmi_resp_t mux_resp;

  dmi_source_mux u_source_mux (
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_req_addr_i   ( jtag_req_addr_i   ),
    .jtag_req_op_i     ( jtag_req_op_i     ),
    .jtag_req_data_i   ( jtag_req_data_i   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_resp_data_o  ( jtag_resp_data_o  ),
    .jtag_resp_code_o  ( jtag_resp_code_o  ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_req_addr_i    ( dtm_req_addr_i    ),
    .dtm_req_op_i      ( dtm_req_op_i      ),
    .dtm_req_data_i    ( dtm_req_data_i    ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_resp_data_o   ( dtm_resp_data_o   ),
    .dtm_resp_code_o   ( dtm_resp_code_o   ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .exit_o            ( exit_o            ),
    .req_valid_o       ( mux_req_valid     ),
    .req_ready_i       ( mux_req_ready     ),
    .req_o             ( mux_req           ),
    .resp_valid_i      ( mux_resp_valid    ),
    .resp_ready_o      ( mux_resp_ready    ),
    .resp_i            ( mux_resp          )
  );

  // ----------------------------------------
  // Request and response buffering
  // ----------------------------------------
  dmi_fifo #(
    .payload_t ( dmi_req_t )
  ) u_req_fifo (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .in_valid_i  ( mux_req_valid ),
    .in_ready_o  ( mux_req_ready ),
    .in_data_i   ( mux_req       ),
    .out_valid_o ( dm_req_valid  ),
    .out_ready_i ( dm_req_ready  ),
    .out_data_o  ( dm_req        )
  );

  dmi_fifo #(
    .payload_t ( dmi_resp_t )
  ) u_resp_fifo (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .in_valid_i  ( dm_resp_valid  ),
    .in_ready_o  ( dm_resp_ready  ),
    .in_data_i   ( dm_resp        ),
    .out_valid_o ( mux_resp_valid ),
    .out_ready_i ( mux_resp_ready ),
    .out_data_o  ( mux_resp       )
  );

  dm_regs u_dm_regs (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .req_valid_i  ( dm_req_valid  ),
    .req_ready_o  ( dm_req_ready  ),
    .req_i        ( dm_req        ),
    .resp_valid_o ( dm_resp_valid ),
    .resp_ready_i ( dm_resp_ready ),
    .resp_o       ( dm_resp       ),
    .debug_req_o  ( debug_req_o   ),
    .ndmreset_o   ( ndmreset_o    )
  );

endmodule

/* dm_regs.sv */
`timescale 1ns/1ps

module dm_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  dmi_pkg::dmi_req_t  req_i,
  output logic               resp_valid_o,
  input  logic               resp_ready_i,
  output dmi_pkg::dmi_resp_t resp_o,
  output logic               debug_req_o,
  output logic               ndmreset_o
);
  import dmi_pkg::*;

  logic [DmiDataWidth-1:0] data_q [NrDataRegs];
  logic                    haltreq_q;
  logic                    ndmreset_q;
  logic                    dmactive_q;
  logic                    resp_valid_q;
  dmi_resp_t               resp_q;
  dmi_resp_t               resp_d;
  logic                    req_fire;
  logic                    data_hit;
  logic                    ctrl_hit;
  data_idx_t               data_idx;
  logic [DmiDataWidth-1:0] dmcontrol;

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  assign data_hit  = (req_i.addr >= DataRegBase) && (req_i.addr <= DataRegLast);
  assign ctrl_hit  = (req_i.addr == DmControlAddr);
  assign data_idx  = data_idx_t'(req_i.addr - DataRegBase);
  assign dmcontrol = {haltreq_q, 29'b0, ndmreset_q, dmactive_q};

  // Output register empty or draining this cycle
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign req_fire    = req_valid_i & req_ready_o;

  always_comb begin
    resp_d.data = '0;
    resp_d.resp = DMI_SUCCESS;
    case (req_i.op)
      DTM_READ: begin
        if (data_hit) begin
          resp_d.data = data_q[data_idx];
        end else if (ctrl_hit) begin
          resp_d.data = dmcontrol;
        end else begin
          resp_d.resp = DMI_FAILED;
        end
      end
      DTM_WRITE: begin
        if (!data_hit && !ctrl_hit) begin
          resp_d.resp = DMI_FAILED;
        end
      end
      default: begin
        // Nop answers with zero data
        resp_d.data = '0;
      end
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_q     <= '{default: '0};
      haltreq_q  <= 1'b0;
      ndmreset_q <= 1'b0;
      dmactive_q <= 1'b0;
    end else if (req_fire && (req_i.op == DTM_WRITE)) begin
      if (data_hit) begin
        data_q[data_idx] <= req_i.data;
      end
      if (ctrl_hit) begin
        haltreq_q  <= req_i.data[31];
        ndmreset_q <= req_i.data[1];
        dmactive_q <= req_i.data[0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_q       <= '0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
      resp_q       <= resp_d;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;
  assign ndmreset_o   = ndmreset_q;

  debug_req_gate u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .haltreq_i   ( haltreq_q   ),
    .debug_req_o ( debug_req_o )
  );

  // Requesters never issue the reserved op
  a_op_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire |-> req_i.op inside {DTM_NOP, DTM_READ, DTM_WRITE});

endmodule

/* debug_req_gate.sv */
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic haltreq_i,
  output logic debug_req_o
);
  import dmi_pkg::*;

  del_cnt_t cnt_q;

  // Hold off halt requests while the core settles after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DelCntInit;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - del_cnt_t'(1);
    end
  end

  assign debug_req_o = haltreq_i & (cnt_q == '0);

endmodule

/* dmi_source_mux.sv */
`timescale 1ns/1ps

module dmi_source_mux (
  input  logic                                jtag_sel_i,

  input  logic                                jtag_req_valid_i,
  output logic                                jtag_req_ready_o,
  input  logic [dmi_pkg::DmiAddrWidth-1:0]    jtag_req_addr_i,
  input  dmi_pkg::dtm_op_e                    jtag_req_op_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0]    jtag_req_data_i,
  output logic                                jtag_resp_valid_o,
  input  logic                                jtag_resp_ready_i,
  output logic [dmi_pkg::DmiDataWidth-1:0]    jtag_resp_data_o,
  output dmi_pkg::dmi_resp_e                  jtag_resp_code_o,

  input  logic                                dtm_req_valid_i,
  output logic                                dtm_req_ready_o,
  input  logic [dmi_pkg::DmiAddrWidth-1:0]    dtm_req_addr_i,
  input  dmi_pkg::dtm_op_e                    dtm_req_op_i,
  input  logic [dmi_pkg::DmiDataWidth-1:0]    dtm_req_data_i,
  output logic                                dtm_resp_valid_o,
  input  logic                                dtm_resp_ready_i,
  output logic [dmi_pkg::DmiDataWidth-1:0]    dtm_resp_data_o,
  output dmi_pkg::dmi_resp_e                  dtm_resp_code_o,

  input  logic [31:0]                         jtag_exit_i,
  input  logic [31:0]                         dtm_exit_i,
  output logic [31:0]                         exit_o,

  output logic                                req_valid_o,
  input  logic                                req_ready_i,
  output dmi_pkg::dmi_req_t                   req_o,
  input  logic                                resp_valid_i,
  output logic                                resp_ready_o,
  input  dmi_pkg::dmi_resp_t                  resp_i
);
  import dmi_pkg::*;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  assign req_valid_o = jtag_sel_i ? jtag_req_valid_i : dtm_req_valid_i;
  assign req_o.addr  = jtag_sel_i ? jtag_req_addr_i  : dtm_req_addr_i;
  assign req_o.op    = jtag_sel_i ? jtag_req_op_i    : dtm_req_op_i;
  assign req_o.data  = jtag_sel_i ? jtag_req_data_i  : dtm_req_data_i;

  // Unselected side never sees ready
  assign jtag_req_ready_o = jtag_sel_i & req_ready_i;
  assign dtm_req_ready_o  = ~jtag_sel_i & req_ready_i;

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  assign resp_ready_o      = jtag_sel_i ? jtag_resp_ready_i : dtm_resp_ready_i;
  assign jtag_resp_valid_o = jtag_sel_i & resp_valid_i;
  assign dtm_resp_valid_o  = ~jtag_sel_i & resp_valid_i;

  // Payload goes to both, valid marks the owner
  assign jtag_resp_data_o = resp_i.data;
  assign jtag_resp_code_o = resp_i.resp;
  assign dtm_resp_data_o  = resp_i.data;
  assign dtm_resp_code_o  = resp_i.resp;

  assign exit_o = jtag_sel_i ? jtag_exit_i : dtm_exit_i;

endmodule

/* dmi_fifo.sv */
`timescale 1ns/1ps

module dmi_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);
  import dmi_pkg::*;

  payload_t  mem_q [DmiFifoDepth];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      push;
  logic      pop;

  assign in_ready_o  = (count_q != FifoFullCnt);
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == FifoLastPtr) ? '0 : wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FifoLastPtr) ? '0 : rd_ptr_q + fifo_ptr_t'(1);
      end
      // Occupancy only moves when one side transfers alone
      if (push && !pop) begin
        count_q <= count_q + fifo_cnt_t'(1);
      end else if (pop && !push) begin
        count_q <= count_q - fifo_cnt_t'(1);
      end
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= FifoFullCnt);

  // Head entry must not change under back-pressure
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> $stable(out_data_o));

endmodule

/* dmi_pkg.sv */
package dmi_pkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int unsigned DmiAddrWidth = 7;
  localparam int unsigned DmiDataWidth = 32;
  localparam int unsigned DmiFifoDepth = 2;
  localparam int unsigned DmiDelCycles = 16;
  localparam int unsigned NrDataRegs   = 8;

  typedef logic [$clog2(DmiFifoDepth)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(DmiFifoDepth+1)-1:0] fifo_cnt_t;
  typedef logic [$clog2(DmiDelCycles+1)-1:0] del_cnt_t;
  typedef logic [$clog2(NrDataRegs)-1:0]     data_idx_t;

  localparam fifo_ptr_t FifoLastPtr = fifo_ptr_t'(DmiFifoDepth - 1);
  localparam fifo_cnt_t FifoFullCnt = fifo_cnt_t'(DmiFifoDepth);
  localparam del_cnt_t  DelCntInit  = del_cnt_t'(DmiDelCycles);

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam logic [DmiAddrWidth-1:0] DataRegBase   = 7'h04;
  localparam logic [DmiAddrWidth-1:0] DataRegLast   =
      DataRegBase + DmiAddrWidth'(NrDataRegs - 1);
  localparam logic [DmiAddrWidth-1:0] DmControlAddr = 7'h10;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'h0,
    DMI_FAILED  = 2'h2
  } dmi_resp_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dtm_op_e                 op;
    logic [DmiDataWidth-1:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [DmiDataWidth-1:0] data;
    dmi_resp_e               resp;
  } dmi_resp_t;

endpackage
